/* hw/rle_vga_config.svh */
`ifndef RLE_VGA_CONFIG_SVH
`define RLE_VGA_CONFIG_SVH

// 640x480 at 60 Hz, 25 MHz pixel clock
`define RLE_H_ACTIVE 640
`define RLE_H_FRONT  16
`define RLE_H_SYNC   96
`define RLE_H_TOTAL  800

// Vertical timing in lines
`define RLE_V_ACTIVE 480
`define RLE_V_FRONT  10
`define RLE_V_SYNC   2
`define RLE_V_TOTAL  525

// Quad-output fast read
`define RLE_FLASH_CMD         8'h6B
`define RLE_CMD_BITS          8
`define RLE_ADDR_BITS         24
`define RLE_DUMMY_CLKS        8
`define RLE_NIBBLES_PER_INSTR 5  // 20 bits, top two dropped

`define RLE_QUEUE_DEPTH 6
`define RLE_PWM_BITS    8

`endif

/* hw/rle_vga_pkg.sv */
package rle_vga_pkg;

    // Opcode in bits 17:16 of every instruction word
    typedef enum logic [1:0] {
        OP_RUN   = 2'b00, // Colour + run length minus one
        OP_AUDIO = 2'b01, // Low byte is the PWM sample
        OP_STOP  = 2'b10, // Restart stream from address zero
        OP_NOP   = 2'b11  // Skipped by the decoder
    } opcode_e;

    // 18-bit instruction as it sits in the queue
    typedef struct packed {
        opcode_e    op;
        logic [7:0] colour; // RGB332, red in the top bits
        logic [7:0] count;  // Run length minus one, or audio sample
    } instr_t;

    // Flash reader sequence
    typedef enum logic [2:0] {
        IDLE,  // cs_n high, only seen in reset
        CMD,   // Read command on di
        ADDR,  // 24 zero address bits
        DUMMY, // Turnaround clocks, di released
        DATA   // Nibbles on io[3:0]
    } qspi_state_e;

endpackage

/* hw/qspi_reader.sv */
`timescale 1ns/1ps

`include "rle_vga_config.svh"

module qspi_reader import rle_vga_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    output logic       sclk,
    output logic       cs_n,
    output logic       di,
    output logic       di_oe,
    output logic       hold_n,
    input  logic [3:0] io,
    input  logic       full,
    output instr_t     instr,
    output logic       instr_valid
);

    localparam logic [7:0] CMD_BYTE = `RLE_FLASH_CMD;

    qspi_state_e state_q;
    logic [4:0]  cnt_q;      // Bits, dummy clocks or nibbles left in phase
    logic        stall;      // Hold SCLK low before the last nibble
    logic        sample_en;  // Rising SCLK edge in DATA
    logic [17:0] shift_q;    // Nibble assembly drops the top two word bits

    // Chip select active from the first cycle after reset
    assign cs_n   = (state_q == IDLE);
    assign hold_n = 1'b1; // Pauses stop SCLK instead of using HOLD
    assign di_oe  = (state_q == CMD) || (state_q == ADDR);
    // Command MSB first and an all-zero address
    assign di     = (state_q == CMD) && CMD_BYTE[cnt_q[2:0]];

    // Only the last nibble waits on the queue
    assign stall     = (state_q == DATA) && !sclk && (cnt_q == 5'd0) && full;
    assign sample_en = (state_q == DATA) && !sclk && !stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            sclk        <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= sample_en && (cnt_q == 5'd0); // Word complete after this nibble
            if (state_q == IDLE) begin
                state_q <= CMD;
                cnt_q   <= 5'(`RLE_CMD_BITS - 1);
            end else if (!sclk) begin
                if (!stall) begin
                    sclk <= 1'b1; // Flash samples di and we sample io here
                end
            end else begin
                sclk <= 1'b0; // Falling edge moves to the next bit
                if (cnt_q != 5'd0) begin
                    cnt_q <= cnt_q - 5'd1;
                end else begin
                    case (state_q)
                        CMD: begin
                            state_q <= ADDR;
                            cnt_q   <= 5'(`RLE_ADDR_BITS - 1);
                        end
                        ADDR: begin
                            state_q <= DUMMY;
                            cnt_q   <= 5'(`RLE_DUMMY_CLKS - 1);
                        end
                        DUMMY: begin
                            state_q <= DATA;
                            cnt_q   <= 5'(`RLE_NIBBLES_PER_INSTR - 1);
                        end
                        default: begin
                            // Next word in DATA
                            cnt_q <= 5'(`RLE_NIBBLES_PER_INSTR - 1);
                        end
                    endcase
                end
            end
        end
    end

    // Nibble shifter
    always_ff @(posedge clk) begin
        if (sample_en) begin
            shift_q <= {shift_q[13:0], io}; // MSB nibble first
        end
    end

    assign instr = instr_t'(shift_q); // Stable during the strobe cycle

endmodule

/* hw/instr_queue.sv */
`timescale 1ns/1ps

`include "rle_vga_config.svh"

module instr_queue import rle_vga_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t instr,
    input  logic   instr_valid,
    output logic   full,
    output instr_t head,
    output logic   head_valid,
    input  logic   pop
);

    localparam int DEPTH = `RLE_QUEUE_DEPTH;

    // Stage 0 takes reader words and stage DEPTH-1 is the head
    instr_t             stage_q [DEPTH];
    logic [DEPTH-1:0]   valid_q;
    logic [DEPTH-1:0]   adv;     // Stage hands its entry forward this cycle
    logic               load;

    // Each stage moves when the one ahead is free or leaving
    always_comb begin
        adv[DEPTH-1] = valid_q[DEPTH-1] && pop;
        for (int i = DEPTH - 2; i >= 0; i--) begin
            adv[i] = valid_q[i] && (!valid_q[i+1] || adv[i+1]);
        end
    end

    assign full = valid_q[0] && !adv[0]; // Entry stuck at the input
    assign load = instr_valid && !full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= (valid_q[0] && !adv[0]) || load;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= (valid_q[i] && !adv[i]) || adv[i-1];
            end
        end
    end

    // Payload shifts along with the valid bits
    always_ff @(posedge clk) begin
        if (load) begin
            stage_q[0] <= instr;
        end
        for (int i = 1; i < DEPTH; i++) begin
            if (adv[i-1]) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign head       = stage_q[DEPTH-1];
    assign head_valid = valid_q[DEPTH-1];

endmodule

/* hw/instruction_decoder.sv */
`timescale 1ns/1ps

module instruction_decoder import rle_vga_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  instr_t     head,
    input  logic       head_valid,
    output logic       pop,
    input  logic       pixel_req,
    output logic [2:0] red,
    output logic [2:0] green,
    output logic [1:0] blue,
    output logic [7:0] sample,
    output logic       stop
);

    logic [7:0] done_q;    // Pixels of the head run already drawn
    logic [7:0] left;      // Pixels after this one
    logic       is_run;
    logic       paint;     // Head run drawn on this pixel
    logic       run_end;

    assign is_run  = head_valid && (head.op == OP_RUN);
    assign paint   = is_run && pixel_req; // Underrun leaves this low
    assign left    = head.count - done_q;
    assign run_end = paint && (left == 8'd0);

    // Non-run words go in one cycle, runs on their last pixel
    assign pop  = (head_valid && !is_run) || run_end;
    assign stop = head_valid && (head.op == OP_STOP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= '0;
        end else if (run_end) begin
            done_q <= '0; // Next run starts fresh
        end else if (paint) begin
            done_q <= done_q + 8'd1;
        end
    end

    // RGB332 unpack, registered so it lines up with the syncs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (paint) begin
            red   <= head.colour[7:5];
            green <= head.colour[4:2];
            blue  <= head.colour[1:0];
        end else begin
            // Blanking or underrun
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
    end

    // Latest audio sample, held until the next one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample <= '0;
        end else if (head_valid && (head.op == OP_AUDIO)) begin
            sample <= head.count;
        end
    end

endmodule

/* hw/vga_timing.sv */
`timescale 1ns/1ps

`include "rle_vga_config.svh"

module vga_timing (
    input  logic clk,
    input  logic rst_n,
    output logic pixel_req,
    output logic hsync,
    output logic vsync
);

    localparam logic [9:0] H_LAST       = 10'(`RLE_H_TOTAL - 1);
    localparam logic [9:0] V_LAST       = 10'(`RLE_V_TOTAL - 1);
    localparam logic [9:0] H_SYNC_START = 10'(`RLE_H_ACTIVE + `RLE_H_FRONT);
    localparam logic [9:0] H_SYNC_END   = 10'(`RLE_H_ACTIVE + `RLE_H_FRONT + `RLE_H_SYNC);
    localparam logic [9:0] V_SYNC_START = 10'(`RLE_V_ACTIVE + `RLE_V_FRONT);
    localparam logic [9:0] V_SYNC_END   = 10'(`RLE_V_ACTIVE + `RLE_V_FRONT + `RLE_V_SYNC);

    logic [9:0] h_cnt_q; // Pixel within line
    logic [9:0] v_cnt_q; // Line within frame

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt_q <= '0;
            v_cnt_q <= '0;
        end else if (h_cnt_q == H_LAST) begin
            h_cnt_q <= '0;
            v_cnt_q <= (v_cnt_q == V_LAST) ? 10'd0 : v_cnt_q + 10'd1;
        end else begin
            h_cnt_q <= h_cnt_q + 10'd1;
        end
    end

    // Straight from the counters, decoder registers the pixel
    assign pixel_req = (h_cnt_q < 10'(`RLE_H_ACTIVE)) && (v_cnt_q < 10'(`RLE_V_ACTIVE));

    // One cycle behind the counters to match registered RGB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= !((h_cnt_q >= H_SYNC_START) && (h_cnt_q < H_SYNC_END));
            vsync <= !((v_cnt_q >= V_SYNC_START) && (v_cnt_q < V_SYNC_END));
        end
    end

endmodule

/* hw/pwm_audio.sv */
`timescale 1ns/1ps

`include "rle_vga_config.svh"

module pwm_audio (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`RLE_PWM_BITS-1:0] sample,
    output logic                     pwm
);

    logic [`RLE_PWM_BITS-1:0] ramp_q; // Wraps every 256 clocks

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ramp_q <= '0;
            pwm    <= 1'b0;
        end else begin
            ramp_q <= ramp_q + 1'b1;
            pwm    <= (ramp_q < sample); // Duty is sample/256
        end
    end

endmodule

/* hw/rle_vga_player.sv */
`timescale 1ns/1ps

module rle_vga_player import rle_vga_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    output logic       sclk,
    output logic       cs_n,
    output logic       di,
    output logic       di_oe,
    output logic       hold_n,
    input  logic [3:0] io,
    output logic [2:0] red,
    output logic [2:0] green,
    output logic [1:0] blue,
    output logic       hsync,
    output logic       vsync,
    output logic       pwm
);

    instr_t     rd_instr;      // Reader to queue
    logic       rd_valid;
    logic       q_full;
    instr_t     q_head;        // Queue to decoder
    logic       q_head_valid;
    logic       dec_pop;
    logic       pixel_req;
    logic [7:0] sample;
    logic       stop;
    logic       soft_rst_n_q;  // Low for one cycle after a stop word
    logic       blk_rst_n;

    // Stop restarts everything from flash address zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            soft_rst_n_q <= 1'b1;
        end else begin
            soft_rst_n_q <= !stop;
        end
    end

    assign blk_rst_n = rst_n && soft_rst_n_q;

    qspi_reader reader0 (
        .clk         (clk),
        .rst_n       (blk_rst_n),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .di          (di),
        .di_oe       (di_oe),
        .hold_n      (hold_n),
        .io          (io),
        .full        (q_full),
        .instr       (rd_instr),
        .instr_valid (rd_valid)
    );

    instr_queue queue0 (
        .clk         (clk),
        .rst_n       (blk_rst_n),
        .instr       (rd_instr),
        .instr_valid (rd_valid),
        .full        (q_full),
        .head        (q_head),
        .head_valid  (q_head_valid),
        .pop         (dec_pop)
    );

    instruction_decoder decoder0 (
        .clk        (clk),
        .rst_n      (blk_rst_n),
        .head       (q_head),
        .head_valid (q_head_valid),
        .pop        (dec_pop),
        .pixel_req  (pixel_req),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .sample     (sample),
        .stop       (stop)
    );

    vga_timing timing0 (
        .clk       (clk),
        .rst_n     (blk_rst_n),
        .pixel_req (pixel_req),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    pwm_audio audio0 (
        .clk    (clk),
        .rst_n  (blk_rst_n),
        .sample (sample),
        .pwm    (pwm)
    );

endmodule

/* verification/tb_rle_vga_player.sv */
`timescale 1ns/1ps

`include "rle_vga_config.svh"

module tb_rle_vga_player import rle_vga_pkg::*; ();

    localparam int MAX_WORDS      = 8192;
    localparam int MAX_RUNS       = 4096;
    localparam int FRAME_CYCLES   = `RLE_H_TOTAL * `RLE_V_TOTAL;
    localparam int TARGET_PIXELS  = 3 * `RLE_H_ACTIVE * `RLE_V_ACTIVE / 2; // About 1.5 frames
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 10000;
    localparam int HS_START       = `RLE_H_ACTIVE + `RLE_H_FRONT;
    localparam int HS_END         = HS_START + `RLE_H_SYNC;
    localparam int VS_START       = `RLE_V_ACTIVE + `RLE_V_FRONT;
    localparam int VS_END         = VS_START + `RLE_V_SYNC;

    logic       clk;
    logic       rst_n;
    logic [3:0] io;
    logic       sclk;
    logic       cs_n;
    logic       di;
    logic       di_oe;
    logic       hold_n;
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
    logic       hsync;
    logic       vsync;
    logic       pwm;

    // Program image and the runs it expands to
    logic [17:0] word_mem [MAX_WORDS];
    logic [7:0]  run_colour [MAX_RUNS];
    logic [7:0]  run_count [MAX_RUNS];
    logic [7:0]  run_sample [MAX_RUNS]; // Audio word just before each run
    int          n_runs = 0;
    integer      seed = 32'hc0b6aa54;

    // Flash model state
    int          bit_cnt = 0;   // Rising SCLK edges since select
    int          nib_addr = 0;
    logic [7:0]  cmd_seen = '0;
    logic [23:0] addr_seen = '0;
    int          oe_err = 0;
    logic [19:0] cur_word;

    // Raster position of the sampled outputs and expected stream position
    int          h = 0;
    int          v = 0;
    int          exp_run = 0;
    int          exp_pix = 0;
    int          restarts = 0;
    int          runs_at_restart = 0;
    int          pix_err = 0;
    logic        cs_prev = 1'b1;
    logic [7:0]  rgb;
    logic [7:0]  long_sample;
    event        long_run_start;

    int          pass_cnt = 0;
    int          fail_cnt = 0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 25 MHz
    end

    rle_vga_player dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .sclk   (sclk),
        .cs_n   (cs_n),
        .di     (di),
        .di_oe  (di_oe),
        .hold_n (hold_n),
        .io     (io),
        .red    (red),
        .green  (green),
        .blue   (blue),
        .hsync  (hsync),
        .vsync  (vsync),
        .pwm    (pwm)
    );

    // Command then address bits MSB first
    always @(posedge sclk) begin
        if (!cs_n) begin
            if (bit_cnt < 8)
                cmd_seen = {cmd_seen[6:0], di};
            else if (bit_cnt < 32)
                addr_seen = {addr_seen[22:0], di};
            else if (di_oe)
                oe_err++; // di must be released from the first dummy clock
            bit_cnt++;
        end
    end

    // Next nibble after each falling SCLK once the dummy clocks are over
    always @(negedge sclk) begin
        #1;
        if (!cs_n && bit_cnt >= 40) begin
            cur_word = {2'b00, word_mem[nib_addr / 5]};
            io = cur_word[4 * (4 - nib_addr % 5) +: 4];
            nib_addr++; // Held across SCLK pauses
        end
    end

    always @(posedge cs_n) begin
        bit_cnt = 0; // Deselect rewinds to address zero
        nib_addr = 0;
        cmd_seen = '0;
        addr_seen = '0;
    end

    task automatic pixel_error(input string msg);
        logic [7:0] want;
        want = (exp_run < n_runs) ? run_colour[exp_run] : 8'h00;
        pix_err++;
        if (pix_err <= 10)
            $display("Mismatch at %0t: %s at h=%0d v=%0d, got %h expected %h",
                     $time, msg, h, v, rgb, want);
    endtask

    task automatic score_pixel();
        if (h < `RLE_H_ACTIVE && v < `RLE_V_ACTIVE) begin
            if (rgb != 8'h00) begin
                if (exp_run >= n_runs || rgb != run_colour[exp_run]) begin
                    pixel_error("wrong colour");
                end else begin
                    if (exp_pix == 0 && exp_run % 8 == 0) begin
                        long_sample = run_sample[exp_run];
                        -> long_run_start; // Long run begins with its sample live
                    end
                    if (exp_pix == int'(run_count[exp_run])) begin
                        exp_run++;
                        exp_pix = 0;
                    end else begin
                        exp_pix++;
                    end
                end
            end else if (exp_pix != 0) begin
                pixel_error("black pixel inside a run"); // Gaps only between words
            end
        end else if (rgb != 8'h00) begin
            pixel_error("colour during blanking");
        end
    endtask

    // Raster origin is the first cycle after any cs_n fall
    always @(negedge clk) begin
        rgb = {red, green, blue};
        if (!cs_n && cs_prev) begin
            if (restarts > 0)
                runs_at_restart = exp_run;
            restarts++;
            h = 0;
            v = 0;
            exp_run = 0;
            exp_pix = 0;
        end else if (h == `RLE_H_TOTAL - 1) begin
            h = 0;
            v = (v == `RLE_V_TOTAL - 1) ? 0 : v + 1;
        end else begin
            h++;
        end
        cs_prev = cs_n;
        if (restarts > 0)
            score_pixel();
    end

    task automatic build_program();
        int n_words;
        int total;
        n_words = 0;
        total = 0;
        while (total < TARGET_PIXELS) begin
            run_sample[n_runs] = 8'($unsigned($random(seed)));
            run_colour[n_runs] = 8'($unsigned($random(seed)) % 255 + 1); // Never black
            // Every eighth run covers a whole PWM period
            run_count[n_runs] = (n_runs % 8 == 0) ? 8'd255
                                                  : 8'($unsigned($random(seed)) % 240 + 15);
            word_mem[n_words] = {OP_AUDIO, 8'h00, run_sample[n_runs]};
            word_mem[n_words + 1] = {OP_RUN, run_colour[n_runs], run_count[n_runs]};
            total += int'(run_count[n_runs]) + 1;
            n_words += 2;
            n_runs++;
        end
        word_mem[n_words] = {OP_STOP, 16'h0000};
        for (int i = n_words + 1; i < MAX_WORDS; i++)
            word_mem[i] = {OP_NOP, 16'(i)}; // Read ahead past the stop but never shown
    endtask

    task automatic report(input string name, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s (%0d errors)", name, errs);
        end
    endtask

    task automatic idle_after_reset();
        int errs;
        errs = 0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            if (i == 2)
                rst_n = 1'b1; // After the third reset edge
            if ({red, green, blue} != 8'h00 || !hsync || !vsync || pwm || sclk) begin
                errs++;
                $display("Mismatch at %0t: outputs not idle in cycle %0d", $time, i);
            end
        end
        report("reset_state", errs);
    endtask

    task automatic flash_read_command();
        int errs;
        errs = 0;
        wait (bit_cnt >= 41); // Past the dummy clocks
        if (cmd_seen != `RLE_FLASH_CMD || addr_seen != 24'h0) begin
            errs++;
            $display("Mismatch at %0t: command %h address %h", $time, cmd_seen, addr_seen);
        end
        if (oe_err != 0 || !hold_n) begin
            errs++;
            $display("Flash pins wrong after the address: di_oe high or hold_n low");
        end
        report("flash_access", errs);
    endtask

    task automatic sync_pulse_timing();
        int errs;
        logic want_h;
        logic want_v;
        errs = 0;
        // One full frame from wherever the raster is
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            @(negedge clk);
            #1;
            want_h = !(h >= HS_START && h < HS_END);
            want_v = !(v >= VS_START && v < VS_END);
            if (hsync != want_h || vsync != want_v) begin
                errs++;
                if (errs <= 10)
                    $display("Mismatch at %0t: syncs %b%b at h=%0d v=%0d",
                             $time, hsync, vsync, h, v);
            end
        end
        report("sync_timing", errs);
    endtask

    task automatic audio_pwm_duty();
        int errs;
        int highs;
        logic [7:0] s;
        errs = 0;
        for (int k = 0; k < 6; k++) begin
            @(long_run_start);
            s = long_sample;
            highs = 0;
            for (int i = 0; i < 256; i++) begin
                if (i > 0)
                    @(negedge clk);
                if (pwm)
                    highs++;
            end
            if (highs != int'(s)) begin
                errs++;
                $display("Mismatch at %0t: pwm high %0d cycles, sample %0d", $time, highs, s);
            end
        end
        report("audio_pwm", errs);
    endtask

    task automatic rle_pixel_stream();
        int errs;
        wait (restarts >= 2); // Stop word reached
        errs = pix_err;
        if (runs_at_restart != n_runs) begin
            errs++;
            $display("Stream restarted after %0d of %0d runs", runs_at_restart, n_runs);
        end
        report("rle_pixels", errs);
    endtask

    task automatic stop_restarts_stream();
        int errs;
        int err0;
        err0 = pix_err;
        errs = 0;
        wait (bit_cnt >= 32); // Command and address of the new read
        if (cmd_seen != `RLE_FLASH_CMD || addr_seen != 24'h0) begin
            errs++;
            $display("Mismatch at %0t: reissued command %h address %h",
                     $time, cmd_seen, addr_seen);
        end
        wait (exp_run >= 4); // First runs drawn again
        errs += pix_err - err0;
        if (restarts != 2) begin
            errs++;
            $display("Chip select toggled %0d times instead of once", restarts - 1);
        end
        if (oe_err != 0) begin
            errs++;
            $display("di_oe was high after the address phase on %0d SCLK edges", oe_err);
        end
        report("stop_restart", errs);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        io = 4'h0;
        build_program();
        idle_after_reset();
        flash_read_command();
        sync_pulse_timing();
        audio_pwm_duty();
        rle_pixel_stream();
        stop_restarts_stream();
        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
hw/rle_vga_pkg.sv
hw/qspi_reader.sv
hw/instr_queue.sv
hw/instruction_decoder.sv
hw/vga_timing.sv
hw/pwm_audio.sv
hw/rle_vga_player.sv
verification/tb_rle_vga_player.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_rle_vga_player \
    -f verilog.f -o sim_rle_vga
./obj_dir/sim_rle_vga | tee sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
